// File: vlog.f
design/operand_pkg.sv
design/bus_master.sv
design/operand_bank.sv
design/op_sequencer.sv
design/operand_unit.sv
verification/mem_model.sv
verification/tb_operand_unit.sv

// File: verification/tb_operand_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_operand_unit;

  // field positions per slot in the order cond, src1, src0, dst
  localparam int num_pos [4]  = '{12, 0, 4, 8};
  localparam int ptr_pos [4]  = '{19, 16, 17, 18};
  localparam int mode_pos [4] = '{26, 20, 22, 24};

  logic        clk;
  logic        rst;
  logic        start;
  logic [31:0] cmd_word;
  logic [31:0] base_addr;
  logic        busy;
  logic        done;
  logic        operands_ready;
  logic [31:0] cond;
  logic [31:0] src1;
  logic [31:0] src0;
  logic        alu_valid;
  logic [31:0] alu_result;
  logic        mem_read;
  logic        mem_write;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;
  logic        mem_read_dn;
  logic        mem_write_dn;

  // reference copy of memory and expected operands
  logic [31:0] shadow [64];
  logic [31:0] exp_cond;
  logic [31:0] exp_src1;
  logic [31:0] exp_src0;
  logic        scan_en;
  int          scan_idx;
  int          value_errors;
  int          protocol_errors;
  logic        timed_out;
  integer      seed;

  operand_unit UUT (.*);
  mem_model u_mem (.*);

  always #10 clk = ~clk;

  task automatic log_mismatch(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    value_errors++;
    $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, want);
  endtask

  task automatic log_protocol(input string msg);
    protocol_errors++;
    $display("protocol error at %0t ns: %s", $time, msg);
  endtask

  // operands held for the whole ALU wait
  a_cond: assert property (@(posedge clk) disable iff (rst) operands_ready |-> cond == exp_cond)
    else log_mismatch("cond", $sampled(cond), exp_cond);
  a_src1: assert property (@(posedge clk) disable iff (rst) operands_ready |-> src1 == exp_src1)
    else log_mismatch("src1", $sampled(src1), exp_src1);
  a_src0: assert property (@(posedge clk) disable iff (rst) operands_ready |-> src0 == exp_src0)
    else log_mismatch("src0", $sampled(src0), exp_src0);
  // memory scan after each command
  a_mem_word: assert property (@(posedge clk) disable iff (rst)
    scan_en |-> u_mem.mem[scan_idx] == shadow[scan_idx])
    else log_mismatch($sformatf("mem[%0d]", scan_idx), u_mem.mem[scan_idx], shadow[scan_idx]);

  a_reset_quiet: assert property (@(posedge clk)
    rst |=> !busy && !done && !operands_ready && !mem_read && !mem_write)
    else log_protocol("outputs not low after reset");
  a_no_rd_wr: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
    else log_protocol("mem_read and mem_write high together");
  a_rd_hold: assert property (@(posedge clk) disable iff (rst)
    mem_read && !mem_read_dn |=> mem_read && $stable(mem_addr))
    else log_protocol("read request dropped or moved before its done pulse");
  a_wr_hold: assert property (@(posedge clk) disable iff (rst)
    mem_write && !mem_write_dn |=> mem_write && $stable(mem_addr) && $stable(mem_wdata))
    else log_protocol("write request dropped or its address or data moved before its done pulse");
  // a start while busy must never open a command later
  a_busy_start: assert property (@(posedge clk) disable iff (rst) $rose(busy) |-> $past(start))
    else log_protocol("busy rose without a start pulse");
  a_ready_hold: assert property (@(posedge clk) disable iff (rst)
    operands_ready && !alu_valid |=> operands_ready)
    else log_protocol("operands_ready dropped before alu_valid");
  a_ready_drop: assert property (@(posedge clk) disable iff (rst)
    operands_ready && alu_valid |=> !operands_ready)
    else log_protocol("operands_ready still high after alu_valid");
  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else log_protocol("done longer than one cycle");
  a_done_busy: assert property (@(posedge clk) disable iff (rst) done == $fell(busy))
    else log_protocol("done not aligned with busy falling");

  function automatic logic watched(input int sel);
    case (sel)
      0: watched = busy;
      1: watched = operands_ready;
      default: watched = done;
    endcase
  endfunction

  task automatic wait_for(input int sel, input string what, input int limit);
    int n;
    n = 0;
    while (!watched(sel) && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!watched(sel)) begin
      log_protocol({"timeout waiting for ", what});
      timed_out = 1'b1;
    end
  endtask

  task automatic preload_memory(input int salt);
    logic [31:0] value;
    int          i;
    for (i = 0; i < 64; i++) begin
      // all words below 64 so pointers stay inside
      value = 32'((i * 13 + salt * 7 + 5) % 64);
      shadow[i] = value;
      u_mem.set_word(i, value);
    end
  endtask

  // expected operands and then the writes applied to the shadow
  task automatic predict(input logic [31:0] cmd, input logic [31:0] base,
                         input logic [31:0] res);
    logic [31:0] reg_val [4];
    logic [31:0] opnd [4];
    logic [5:0]  reg_addr [4];
    logic [1:0]  mode;
    int          s;
    int          k;
    for (s = 0; s < 4; s++) begin
      reg_addr[s] = 6'(base + 32'(cmd[num_pos[s] +: 4]));
      reg_val[s]  = shadow[reg_addr[s]];
      opnd[s]     = cmd[ptr_pos[s]] ? shadow[reg_val[s][5:0]] : reg_val[s];
    end
    exp_cond = opnd[0];
    exp_src1 = opnd[1];
    exp_src0 = opnd[2];
    if (cmd[ptr_pos[3]]) begin
      shadow[reg_val[3][5:0]] = res;
    end else begin
      shadow[reg_addr[3]] = res;
    end
    // post-modify walks dst, cond, src1, src0
    for (k = 0; k < 4; k++) begin
      s    = (k + 3) % 4;
      mode = cmd[mode_pos[s] +: 2];
      // plain dst keeps the result
      if (s == 3 && !cmd[ptr_pos[3]]) begin
        mode = 2'b00;
      end
      if (mode == 2'b01) begin
        shadow[reg_addr[s]] = reg_val[s] + 1;
      end else if (mode == 2'b10) begin
        shadow[reg_addr[s]] = reg_val[s] - 1;
      end
    end
  endtask

  task automatic run_command(input logic [31:0] cmd, input logic [31:0] base,
                             input int salt, input logic extra_start);
    logic [31:0] result_val;
    int          alu_delay;
    int          i;
    preload_memory(salt);
    result_val = $random(seed);
    alu_delay  = {$random(seed)} % 5;
    predict(cmd, base, result_val);
    cmd_word  = cmd;
    base_addr = base;
    start     = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    wait_for(0, "busy", 4);
    if (extra_start && !timed_out) begin
      // different command while busy that must be dropped
      cmd_word  = ~cmd;
      base_addr = base + 3;
      start     = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
    end
    if (!timed_out) begin
      wait_for(1, "operands_ready", 400);
    end
    if (!timed_out) begin
      repeat (alu_delay) begin
        @(posedge clk);
        #1;
      end
      alu_valid  = 1'b1;
      alu_result = result_val;
      @(posedge clk);
      #1;
      alu_valid = 1'b0;
      wait_for(2, "done", 400);
    end
    if (!timed_out) begin
      scan_en = 1'b1;
      for (i = 0; i < 64; i++) begin
        scan_idx = i;
        @(posedge clk);
        #1;
      end
      scan_en = 1'b0;
    end
  endtask

  initial begin
    int n;
    seed            = 7085;
    value_errors    = 0;
    protocol_errors = 0;
    timed_out       = 1'b0;
    clk             = 1'b0;
    rst             = 1'b1;
    start           = 1'b0;
    cmd_word        = '0;
    base_addr       = '0;
    alu_valid       = 1'b0;
    alu_result      = '0;
    scan_en         = 1'b0;
    scan_idx        = 0;
    exp_cond        = '0;
    exp_src1        = '0;
    exp_src0        = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    // direct fields with the top nibble ignored
    run_command(32'hF000_1432, 32'd8, 1, 1'b0);
    // pointer cond, src0 and dst with dst inc and cond dec
    if (!timed_out) begin
      run_command(32'h090E_5A67, 32'd16, 2, 1'b0);
    end
    // r3 shared by cond, dst, src0
    if (!timed_out) begin
      run_command(32'h0D91_3339, 32'd32, 3, 1'b0);
    end
    // pointer dst on r2 shared with cond and src1 plus a start while busy
    if (!timed_out) begin
      run_command(32'h0914_2252, 32'd40, 4, 1'b1);
    end
    for (n = 0; n < 6 && !timed_out; n++) begin
      run_command($random(seed) & 32'h0FFF_FFFF, 1 + {$random(seed)} % 48, 10 + n, 1'b0);
    end
    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic        mem_read,
  input  logic        mem_write,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  output logic [31:0] mem_rdata,
  output logic        mem_read_dn,
  output logic        mem_write_dn
);

  // 64 words, upper address bits wrap
  logic [31:0] mem [64];
  integer      seed;
  logic        active;
  int          wait_cnt;
  logic [31:0] pick;

  initial begin
    seed         = 7085;
    active       = 1'b0;
    wait_cnt     = 0;
    mem_rdata    = '0;
    mem_read_dn  = 1'b0;
    mem_write_dn = 1'b0;
  end

  // backdoor load from the testbench
  task automatic set_word(input int idx, input logic [31:0] value);
    mem[idx] = value;
  endtask

  always @(posedge clk) begin
    mem_read_dn  <= #1 1'b0;
    mem_write_dn <= #1 1'b0;
    if (rst) begin
      active <= 1'b0;
    end else if (active) begin
      if (wait_cnt == 0) begin
        active <= 1'b0;
        if (mem_read) begin
          mem_rdata   <= #1 mem[mem_addr[5:0]];
          mem_read_dn <= #1 1'b1;
        end else begin
          mem[mem_addr[5:0]] <= mem_wdata;
          mem_write_dn       <= #1 1'b1;
        end
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    // new request, skipping the one answered last cycle
    end else if ((mem_read || mem_write) && !mem_read_dn && !mem_write_dn) begin
      pick     = $random(seed);
      // 0 to 5 idle cycles
      wait_cnt <= pick % 6;
      active   <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/operand_unit.sv
`timescale 1ns/1ps
`default_nettype none

module operand_unit (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  logic [operand_pkg::data_w-1:0] cmd_word,
  input  logic [operand_pkg::addr_w-1:0] base_addr,
  output logic                           busy,
  output logic                           done,
  output logic                           operands_ready,
  output logic [operand_pkg::data_w-1:0] cond,
  output logic [operand_pkg::data_w-1:0] src1,
  output logic [operand_pkg::data_w-1:0] src0,
  input  logic                           alu_valid,
  input  logic [operand_pkg::data_w-1:0] alu_result,
  output logic                           mem_read,
  output logic                           mem_write,
  output logic [operand_pkg::addr_w-1:0] mem_addr,
  output logic [operand_pkg::data_w-1:0] mem_wdata,
  input  logic [operand_pkg::data_w-1:0] mem_rdata,
  input  logic                           mem_read_dn,
  input  logic                           mem_write_dn
);

  import operand_pkg::*;

  // sequencer to bank
  slot_t             slot_sel;
  logic              load_cmd;
  logic              cap_reg;
  logic              cap_operand;
  logic              load_result;
  // bank back to sequencer
  logic [addr_w-1:0] slot_reg_addr;
  logic              slot_is_ptr;
  logic              slot_needs_wb;
  logic [data_w-1:0] slot_reg_val;
  logic [data_w-1:0] slot_wb_val;
  logic [data_w-1:0] result;
  // sequencer and bus master
  logic              req_read;
  logic              req_write;
  logic [addr_w-1:0] req_addr;
  logic [data_w-1:0] req_wdata;
  logic              req_done;
  logic [data_w-1:0] req_data;

  op_sequencer u_seq (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .alu_valid      (alu_valid),
    .slot_reg_addr  (slot_reg_addr),
    .slot_is_ptr    (slot_is_ptr),
    .slot_needs_wb  (slot_needs_wb),
    .slot_reg_val   (slot_reg_val),
    .slot_wb_val    (slot_wb_val),
    .result         (result),
    .req_done       (req_done),
    .req_data       (req_data),
    .busy           (busy),
    .done           (done),
    .operands_ready (operands_ready),
    .slot_sel       (slot_sel),
    .load_cmd       (load_cmd),
    .cap_reg        (cap_reg),
    .cap_operand    (cap_operand),
    .load_result    (load_result),
    .req_read       (req_read),
    .req_write      (req_write),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata)
  );

  // returned bus words feed the bank directly
  operand_bank u_bank (
    .clk           (clk),
    .rst           (rst),
    .load_cmd      (load_cmd),
    .cmd_word      (cmd_word),
    .base_addr     (base_addr),
    .slot_sel      (slot_sel),
    .cap_reg       (cap_reg),
    .cap_operand   (cap_operand),
    .cap_data      (req_data),
    .load_result   (load_result),
    .alu_result    (alu_result),
    .slot_reg_addr (slot_reg_addr),
    .slot_is_ptr   (slot_is_ptr),
    .slot_needs_wb (slot_needs_wb),
    .slot_reg_val  (slot_reg_val),
    .slot_wb_val   (slot_wb_val),
    .cond          (cond),
    .src1          (src1),
    .src0          (src0),
    .result        (result)
  );

  bus_master u_bus (
    .clk          (clk),
    .rst          (rst),
    .req_read     (req_read),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_done     (req_done),
    .req_data     (req_data),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata),
    .mem_read_dn  (mem_read_dn),
    .mem_write_dn (mem_write_dn)
  );

endmodule

`default_nettype wire

// File: design/op_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module op_sequencer (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  logic                           alu_valid,
  input  logic [operand_pkg::addr_w-1:0] slot_reg_addr,
  input  logic                           slot_is_ptr,
  input  logic                           slot_needs_wb,
  input  logic [operand_pkg::data_w-1:0] slot_reg_val,
  input  logic [operand_pkg::data_w-1:0] slot_wb_val,
  input  logic [operand_pkg::data_w-1:0] result,
  input  logic                           req_done,
  input  logic [operand_pkg::data_w-1:0] req_data,
  output logic                           busy,
  output logic                           done,
  output logic                           operands_ready,
  output operand_pkg::slot_t             slot_sel,
  output logic                           load_cmd,
  output logic                           cap_reg,
  output logic                           cap_operand,
  output logic                           load_result,
  output logic                           req_read,
  output logic                           req_write,
  output logic [operand_pkg::addr_w-1:0] req_addr,
  output logic [operand_pkg::data_w-1:0] req_wdata
);

  import operand_pkg::*;

  seq_state_t        state;
  seq_state_t        state_nx;
  slot_t             slot_nx;
  // a bus transfer is outstanding
  logic              pending;
  logic              pending_nx;
  logic              issue_rd;
  logic              issue_wr;
  logic [addr_w-1:0] issue_addr;
  logic [data_w-1:0] issue_data;
  logic              wb_this;

  // fetch order cond, src1, src0, dst
  // writeback order dst, cond, src1, src0 by wrapping
  function automatic slot_t next_slot(input slot_t s);
    case (s)
      slot_cond: next_slot = slot_src1;
      slot_src1: next_slot = slot_src0;
      slot_src0: next_slot = slot_dst;
      default:   next_slot = slot_cond;
    endcase
  endfunction

  // plain dst never gets a post-modify write
  assign wb_this = slot_needs_wb && ((slot_sel != slot_dst) || slot_is_ptr);

  always_comb begin
    state_nx   = state;
    slot_nx    = slot_sel;
    pending_nx = pending;
    issue_rd   = 1'b0;
    issue_wr   = 1'b0;
    issue_addr = slot_reg_addr;
    issue_data = slot_wb_val;
    case (state)
      st_idle, st_finish: begin
        state_nx = st_idle;
        if (start) begin
          state_nx = st_fetch_reg;
          slot_nx  = slot_cond;
        end
      end
      st_fetch_reg: begin
        if (!pending) begin
          issue_rd   = 1'b1;
          pending_nx = 1'b1;
        end else if (req_done) begin
          if (slot_is_ptr && (slot_sel != slot_dst)) begin
            // chase the pointer right away
            issue_rd   = 1'b1;
            issue_addr = req_data;
            state_nx   = st_fetch_ptr;
          end else begin
            pending_nx = 1'b0;
            if (slot_sel == slot_dst) begin
              state_nx = st_wait_alu;
            end else begin
              slot_nx = next_slot(slot_sel);
            end
          end
        end
      end
      st_fetch_ptr: begin
        if (req_done) begin
          pending_nx = 1'b0;
          slot_nx    = next_slot(slot_sel);
          state_nx   = st_fetch_reg;
        end
      end
      st_wait_alu: begin
        // slot_sel still points at dst
        if (alu_valid) begin
          state_nx = st_write_result;
        end
      end
      st_write_result: begin
        if (!pending) begin
          issue_wr   = 1'b1;
          issue_addr = slot_is_ptr ? slot_reg_val : slot_reg_addr;
          issue_data = result;
          pending_nx = 1'b1;
        end else if (req_done) begin
          pending_nx = 1'b0;
          state_nx   = st_write_reg;
        end
      end
      st_write_reg: begin
        if (!pending && wb_this) begin
          issue_wr   = 1'b1;
          pending_nx = 1'b1;
        end else if (!pending || req_done) begin
          pending_nx = 1'b0;
          if (slot_sel == slot_src0) begin
            state_nx = st_finish;
          end else begin
            slot_nx = next_slot(slot_sel);
          end
        end
      end
      default: state_nx = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      slot_sel  <= slot_cond;
      pending   <= 1'b0;
      req_read  <= 1'b0;
      req_write <= 1'b0;
    end else begin
      state     <= state_nx;
      slot_sel  <= slot_nx;
      pending   <= pending_nx;
      req_read  <= issue_rd;
      req_write <= issue_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_rd || issue_wr) begin
      req_addr  <= issue_addr;
      req_wdata <= issue_data;
    end
  end

  // bank strobes
  assign load_cmd    = start && ((state == st_idle) || (state == st_finish));
  assign cap_reg     = (state == st_fetch_reg) && pending && req_done;
  assign cap_operand = (state == st_fetch_ptr) && req_done;
  assign load_result = (state == st_wait_alu) && alu_valid;

  // status, busy already low in the done cycle
  assign busy           = (state != st_idle) && (state != st_finish);
  assign done           = (state == st_finish);
  assign operands_ready = (state == st_wait_alu);

  // one transfer at a time toward the bus master
  a_one_request: assert property (@(posedge clk) disable iff (rst)
    (req_read || req_write) |=> (!req_read && !req_write) until_with req_done);

endmodule

`default_nettype wire

// File: design/operand_bank.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bank (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           load_cmd,
  input  logic [operand_pkg::data_w-1:0] cmd_word,
  input  logic [operand_pkg::addr_w-1:0] base_addr,
  input  operand_pkg::slot_t             slot_sel,
  input  logic                           cap_reg,
  input  logic                           cap_operand,
  input  logic [operand_pkg::data_w-1:0] cap_data,
  input  logic                           load_result,
  input  logic [operand_pkg::data_w-1:0] alu_result,
  output logic [operand_pkg::addr_w-1:0] slot_reg_addr,
  output logic                           slot_is_ptr,
  output logic                           slot_needs_wb,
  output logic [operand_pkg::data_w-1:0] slot_reg_val,
  output logic [operand_pkg::data_w-1:0] slot_wb_val,
  output logic [operand_pkg::data_w-1:0] cond,
  output logic [operand_pkg::data_w-1:0] src1,
  output logic [operand_pkg::data_w-1:0] src0,
  output logic [operand_pkg::data_w-1:0] result
);

  import operand_pkg::*;

  logic [data_w-1:0]    cmd_q;
  logic [addr_w-1:0]    base_q;
  logic [reg_num_w-1:0] reg_num [4];
  logic                 is_ptr [4];
  mode_t                mode [4];
  // register values as fetched at command start
  logic [data_w-1:0]    reg_val [4];

  // command word and base held for the whole command
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_q <= '0;
    end else if (load_cmd) begin
      cmd_q <= cmd_word;
    end
  end

  always_ff @(posedge clk) begin
    if (load_cmd) begin
      base_q <= base_addr;
    end
  end

  // field decode per slot
  always_comb begin
    reg_num[slot_cond] = cmd_q[num_lsb_cond +: reg_num_w];
    reg_num[slot_src1] = cmd_q[num_lsb_src1 +: reg_num_w];
    reg_num[slot_src0] = cmd_q[num_lsb_src0 +: reg_num_w];
    reg_num[slot_dst]  = cmd_q[num_lsb_dst +: reg_num_w];
    is_ptr[slot_cond]  = cmd_q[ptr_bit_cond];
    is_ptr[slot_src1]  = cmd_q[ptr_bit_src1];
    is_ptr[slot_src0]  = cmd_q[ptr_bit_src0];
    is_ptr[slot_dst]   = cmd_q[ptr_bit_dst];
    mode[slot_cond]    = mode_t'(cmd_q[mode_lsb_cond +: $bits(mode_t)]);
    mode[slot_src1]    = mode_t'(cmd_q[mode_lsb_src1 +: $bits(mode_t)]);
    mode[slot_src0]    = mode_t'(cmd_q[mode_lsb_src0 +: $bits(mode_t)]);
    mode[slot_dst]     = mode_t'(cmd_q[mode_lsb_dst +: $bits(mode_t)]);
  end

  // register words, operand words and result
  always_ff @(posedge clk) begin
    if (cap_reg) begin
      reg_val[slot_sel] <= cap_data;
    end
    // pointer fetch replaces the operand only
    if (cap_reg || cap_operand) begin
      case (slot_sel)
        slot_cond: cond <= cap_data;
        slot_src1: src1 <= cap_data;
        slot_src0: src0 <= cap_data;
        default:   ;
      endcase
    end
    if (load_result) begin
      result <= alu_result;
    end
  end

  // view of the selected slot
  assign slot_reg_addr = base_q + addr_w'(reg_num[slot_sel]);
  assign slot_is_ptr   = is_ptr[slot_sel];
  assign slot_needs_wb = (mode[slot_sel] == mode_inc) || (mode[slot_sel] == mode_dec);
  assign slot_reg_val  = reg_val[slot_sel];

  // post-modified register value
  always_comb begin
    case (mode[slot_sel])
      mode_inc: slot_wb_val = reg_val[slot_sel] + data_w'(1);
      mode_dec: slot_wb_val = reg_val[slot_sel] - data_w'(1);
      default:  slot_wb_val = reg_val[slot_sel];
    endcase
  end

  a_one_capture: assert property (@(posedge clk) disable iff (rst)
    !(cap_reg && cap_operand));

endmodule

`default_nettype wire

// File: design/bus_master.sv
`timescale 1ns/1ps
`default_nettype none

module bus_master (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           req_read,
  input  logic                           req_write,
  input  logic [operand_pkg::addr_w-1:0] req_addr,
  input  logic [operand_pkg::data_w-1:0] req_wdata,
  output logic                           req_done,
  output logic [operand_pkg::data_w-1:0] req_data,
  output logic                           mem_read,
  output logic                           mem_write,
  output logic [operand_pkg::addr_w-1:0] mem_addr,
  output logic [operand_pkg::data_w-1:0] mem_wdata,
  input  logic [operand_pkg::data_w-1:0] mem_rdata,
  input  logic                           mem_read_dn,
  input  logic                           mem_write_dn
);

  import operand_pkg::*;

  bus_op_t             op;
  logic [addr_w-1:0]   addr_q;
  logic [data_w-1:0]   wdata_q;
  logic                accept;
  logic                finish;

  // new transfer only from idle
  assign accept = (op == bus_idle) && (req_read || req_write);
  // matching done pulse ends the held level
  assign finish = ((op == bus_read) && mem_read_dn) ||
                  ((op == bus_write) && mem_write_dn);

  always_ff @(posedge clk) begin
    if (rst) begin
      op       <= bus_idle;
      req_done <= 1'b0;
    end else begin
      req_done <= finish;
      if (accept) begin
        // read wins if both show up
        op <= req_read ? bus_read : bus_write;
      end else if (finish) begin
        op <= bus_idle;
      end
    end
  end

  // latched request and returned word
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
    if ((op == bus_read) && mem_read_dn) begin
      req_data <= mem_rdata;
    end
  end

  // levels follow the active transfer
  assign mem_read  = (op == bus_read);
  assign mem_write = (op == bus_write);
  assign mem_addr  = addr_q;
  assign mem_wdata = wdata_q;

  // both strobes would only be wanted if both requests came at once
  a_no_rd_wr: assert property (@(posedge clk) disable iff (rst)
    !(req_read && req_write));

  // address and data held until the done pulse
  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    ((mem_read && !mem_read_dn) || (mem_write && !mem_write_dn))
      |=> $stable(mem_addr) && $stable(mem_wdata));

endmodule

`default_nettype wire

// File: design/operand_pkg.sv
`default_nettype none

package operand_pkg;

  // data path widths
  localparam int data_w    = 32;
  localparam int addr_w    = 32;
  // registers r0..r15 live at base_addr + n
  localparam int reg_num_w = 4;

  // register number fields of the command word
  localparam int num_lsb_src1  = 0;
  localparam int num_lsb_src0  = 4;
  localparam int num_lsb_dst   = 8;
  localparam int num_lsb_cond  = 12;

  // pointer flags, one per field
  localparam int ptr_bit_src1  = 16;
  localparam int ptr_bit_src0  = 17;
  localparam int ptr_bit_dst   = 18;
  localparam int ptr_bit_cond  = 19;

  // two-bit post-modify modes
  // bits 28..31 carry nothing for this unit
  localparam int mode_lsb_src1 = 20;
  localparam int mode_lsb_src0 = 22;
  localparam int mode_lsb_dst  = 24;
  localparam int mode_lsb_cond = 26;

  // only inc and dec write the register back
  typedef enum logic [1:0] {
    mode_none = 2'b00,
    mode_inc  = 2'b01,
    mode_dec  = 2'b10,
    mode_keep = 2'b11
  } mode_t;

  // slot order doubles as fetch order
  // writeback starts at dst and wraps to cond
  typedef enum logic [1:0] {
    slot_cond,
    slot_src1,
    slot_src0,
    slot_dst
  } slot_t;

  // sequencer states
  typedef enum logic [2:0] {
    st_idle,
    st_fetch_reg,
    st_fetch_ptr,
    st_wait_alu,
    st_write_result,
    st_write_reg,
    st_finish
  } seq_state_t;

  // active transfer of the bus master
  typedef enum logic [1:0] {
    bus_idle,
    bus_read,
    bus_write
  } bus_op_t;

endpackage

`default_nettype wire
